// File: common/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    // ************************************************************************
    // Serial timing

    localparam int clock_frequency        = 25_000_000;
    localparam int baud_rate              = 115_200;
    localparam int clock_cycles_in_symbol = clock_frequency / baud_rate;
    localparam int first_sample_count     = clock_cycles_in_symbol * 3 / 2;  // Middle of bit 0
    localparam int symbol_counter_width   = $clog2(first_sample_count + 1);

    // ************************************************************************
    // Frame buffer and register map

    localparam int fifo_depth         = 8;
    localparam int fifo_count_width   = $clog2(fifo_depth + 1);
    localparam int fifo_address_width = $clog2(fifo_depth);

    localparam logic [1:0] reg_data_address   = 2'd0;
    localparam logic [1:0] reg_status_address = 2'd1;

    typedef struct packed
    {
        logic       stop_error;  // Stop bit sampled low
        logic [7:0] data;
    } rx_frame_t;

    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [ 1:0] adr;  // Word address
        logic [31:0] dat;
    } wb_request_t;

    typedef struct packed
    {
        logic        ack;
        logic [31:0] dat;
    } wb_response_t;

endpackage

`default_nettype wire

// File: uart_receiver/uart_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module uart_receiver
    import uart_rx_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      rx,
    output rx_frame_t frame,
    output logic      frame_valid
);

    typedef enum logic [1:0]
    {
        state_idle,
        state_data,
        state_stop
    } state_t;

    state_t state;
    state_t next_state;

    // ************************************************************************
    // Input synchronizer and start edge

    logic rx_sync_1;
    logic rx_sync;
    logic rx_previous;

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            rx_sync_1   <= 1'b1;
            rx_sync     <= 1'b1;
            rx_previous <= 1'b1;
        end
        else
        begin
            rx_sync_1   <= rx;
            rx_sync     <= rx_sync_1;
            rx_previous <= rx_sync;
        end
    end

    wire start_edge = rx_previous && !rx_sync;

    // ************************************************************************
    // Symbol counter

    logic [symbol_counter_width-1:0] counter;
    logic [symbol_counter_width-1:0] load_value;
    logic                            load_counter;

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            counter <= '0;
        else if (load_counter)
            counter <= load_value;
        else if (counter != '0)
            counter <= counter - 1'b1;
    end

    wire counter_done = counter == symbol_counter_width'(1);

    // ************************************************************************
    // Control

    logic       start_frame;
    logic       sample_data;
    logic       sample_stop;
    logic [7:0] bit_marker;  // One-hot, walks right per data bit

    always_comb
    begin
        next_state   = state;
        start_frame  = 1'b0;
        sample_data  = 1'b0;
        sample_stop  = 1'b0;
        load_counter = 1'b0;
        load_value   = '0;

        case (state)
            state_idle:
                if (start_edge)
                begin
                    start_frame  = 1'b1;
                    load_counter = 1'b1;
                    load_value   = symbol_counter_width'(first_sample_count);
                    next_state   = state_data;
                end
            state_data:
                if (counter_done)
                begin
                    sample_data  = 1'b1;
                    load_counter = 1'b1;
                    load_value   = symbol_counter_width'(clock_cycles_in_symbol);
                    if (bit_marker[0])
                        next_state = state_stop;  // Eighth bit taken
                end
            state_stop:
                if (counter_done)
                begin
                    sample_stop = 1'b1;
                    next_state  = state_idle;
                end
            default:
                next_state = state_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state       <= state_idle;
            bit_marker  <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            state       <= next_state;
            frame_valid <= sample_stop;

            if (start_frame)
                bit_marker <= 8'b1000_0000;
            else if (sample_data)
                bit_marker <= bit_marker >> 1;
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clock)
    begin
        if (sample_data)
            frame.data <= { rx_sync, frame.data[7:1] };

        if (sample_stop)
            frame.stop_error <= !rx_sync;
    end

endmodule

`default_nettype wire

// File: source/rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rx_fifo
    import uart_rx_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        push,
    input  rx_frame_t                   push_frame,
    input  logic                        pop,
    output rx_frame_t                   front,
    output logic                        empty,
    output logic [fifo_count_width-1:0] count,
    output logic                        overflow
);

    rx_frame_t buffer [fifo_depth];

    logic [fifo_address_width-1:0] write_pointer;
    logic [fifo_address_width-1:0] read_pointer;
    logic                          full;
    logic                          do_push;
    logic                          do_pop;

    assign empty    = count == '0;
    assign full     = count == fifo_count_width'(fifo_depth);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign overflow = push && full;  // Frame is lost
    assign front    = buffer[read_pointer];

    always_ff @(posedge clock)
    begin
        if (do_push)
            buffer[write_pointer] <= push_frame;
    end

    // ************************************************************************
    // Pointers and occupancy

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end
        else
        begin
            if (do_push)
                write_pointer <= write_pointer + 1'b1;  // Wraps at depth

            if (do_pop)
                read_pointer <= read_pointer + 1'b1;

            case ({ do_push, do_pop })
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/rx_wb_port.sv
`timescale 1ns/1ns
`default_nettype none

module rx_wb_port
    import uart_rx_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset_n,
    input  wb_request_t                 wb_request,
    output wb_response_t                wb_response,
    input  rx_frame_t                   front,
    input  logic                        empty,
    input  logic [fifo_count_width-1:0] count,
    input  logic                        overflow,
    output logic                        pop
);

    logic        ack;
    logic        overrun;
    logic        data_access;
    logic        status_access;
    logic        clear_overrun;
    logic [31:0] read_word;

    wire access = wb_request.cyc && wb_request.stb;

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            ack <= 1'b0;
        else
            ack <= access && !ack;  // Single cycle
    end

    assign data_access   = ack && wb_request.adr == reg_data_address;
    assign status_access = ack && wb_request.adr == reg_status_address;

    assign pop           = data_access && !wb_request.we && !empty;
    assign clear_overrun = status_access && wb_request.we && wb_request.dat[8];

    // ************************************************************************
    // Sticky overrun

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            overrun <= 1'b0;
        else if (overflow)
            overrun <= 1'b1;
        else if (clear_overrun)
            overrun <= 1'b0;
    end

    // ************************************************************************
    // Read data

    always_comb
    begin
        read_word = '0;

        if (data_access && !wb_request.we && !empty)
        begin
            read_word[7:0] = front.data;
            read_word[8]   = front.stop_error;
            read_word[9]   = 1'b1;  // Valid
        end
        else if (status_access && !wb_request.we)
        begin
            read_word[fifo_count_width-1:0] = count;
            read_word[8]                    = overrun;
        end
    end

    assign wb_response.ack = ack;
    assign wb_response.dat = read_word;

endmodule

`default_nettype wire

// File: source/uart_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_top
    import uart_rx_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic         rx,
    input  wb_request_t  wb_request,
    output wb_response_t wb_response
);

    rx_frame_t                   frame;
    rx_frame_t                   front;
    logic                        frame_valid;
    logic                        empty;
    logic                        pop;
    logic                        overflow;
    logic [fifo_count_width-1:0] count;

    uart_receiver receiver
    (
        .clock       ( clock       ),
        .reset_n     ( reset_n     ),
        .rx          ( rx          ),
        .frame       ( frame       ),
        .frame_valid ( frame_valid )
    );

    rx_fifo fifo
    (
        .clock      ( clock       ),
        .reset_n    ( reset_n     ),
        .push       ( frame_valid ),
        .push_frame ( frame       ),
        .pop        ( pop         ),
        .front      ( front       ),
        .empty      ( empty       ),
        .count      ( count       ),
        .overflow   ( overflow    )
    );

    rx_wb_port wb_port
    (
        .clock       ( clock       ),
        .reset_n     ( reset_n     ),
        .wb_request  ( wb_request  ),
        .wb_response ( wb_response ),
        .front       ( front       ),
        .empty       ( empty       ),
        .count       ( count       ),
        .overflow    ( overflow    ),
        .pop         ( pop         )
    );

endmodule

`default_nettype wire

// File: dv/uart_rx_properties.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_properties
    import uart_rx_pkg::*;
(
    input logic                        clock,
    input logic                        reset_n,
    input wb_request_t                 wb_request,
    input wb_response_t                wb_response,
    input logic [fifo_count_width-1:0] count,
    input logic                        empty,
    input logic                        pop
);

    // ************************************************************************
    // Wishbone handshake

    ack_needs_request: assert property (@(posedge clock) disable iff (!reset_n)
        wb_response.ack |-> $past(wb_request.cyc && wb_request.stb))
        else $error("Ack raised without cyc and stb in the previous cycle");

    ack_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        wb_response.ack |=> !wb_response.ack)
        else $error("Ack held for two cycles in a row");

    // ************************************************************************
    // FIFO occupancy

    count_in_range: assert property (@(posedge clock) disable iff (!reset_n)
        count <= fifo_count_width'(fifo_depth))
        else $error("FIFO count above its depth");

    pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !empty)
        else $error("Pop issued while the FIFO is empty");

endmodule

bind uart_rx_top uart_rx_properties properties
(
    .clock       ( clock       ),
    .reset_n     ( reset_n     ),
    .wb_request  ( wb_request  ),
    .wb_response ( wb_response ),
    .count       ( count       ),
    .empty       ( empty       ),
    .pop         ( pop         )
);

`default_nettype wire

// File: dv/uart_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_tb
    import uart_rx_pkg::*;
();

    logic         clock;
    logic         reset_n;
    logic         rx;
    wb_request_t  wb_request;
    wb_response_t wb_response;

    rx_frame_t model_queue [$];  // Frames the FIFO should hold
    logic      model_overrun;
    string     test_name;

    always #2 clock = ~clock;

    uart_rx_top uut
    (
        .clock       ( clock       ),
        .reset_n     ( reset_n     ),
        .rx          ( rx          ),
        .wb_request  ( wb_request  ),
        .wb_response ( wb_response )
    );

    // ************************************************************************
    // Reference model

    function automatic void record_frame(input logic [7:0] data, input logic stop_error);
        rx_frame_t sent;
        sent.data       = data;
        sent.stop_error = stop_error;
        if (model_queue.size() < fifo_depth)
            model_queue.push_back(sent);
        else
            model_overrun = 1'b1;  // Dropped by a full FIFO
    endfunction

    function automatic logic [31:0] expected_data_word();
        rx_frame_t oldest;
        if (model_queue.size() == 0)
            return 32'h0;
        oldest = model_queue[0];
        return { 22'h0, 1'b1, oldest.stop_error, oldest.data };
    endfunction

    function automatic logic [31:0] expected_status_word();
        return { 23'h0, model_overrun, 8'(model_queue.size()) };
    endfunction

    // ************************************************************************
    // Checking

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
                                name, expected, actual));
    endtask

    // Every data read in its ack cycle
    always @(negedge clock)
    begin
        if (reset_n && wb_response.ack && !wb_request.we && wb_request.adr == reg_data_address)
        begin
            check_value(test_name, expected_data_word(), wb_response.dat);
            if (model_queue.size() != 0)
                void'(model_queue.pop_front());
        end
    end

    // ************************************************************************
    // Serial line and bus master

    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        record_frame(data, !stop_level);
        rx = 1'b0;  // Start bit
        repeat (clock_cycles_in_symbol) @(negedge clock);
        for (int i = 0; i < 8; i++)
        begin
            rx = data[i];
            repeat (clock_cycles_in_symbol) @(negedge clock);
        end
        rx = stop_level;
        repeat (clock_cycles_in_symbol) @(negedge clock);
        rx = 1'b1;  // Idle symbol
        repeat (clock_cycles_in_symbol) @(negedge clock);
    endtask

    task automatic bus_access(input logic write, input logic [1:0] address,
                              input logic [31:0] write_data, output logic [31:0] read_data);
        int cycles;
        cycles         = 0;
        wb_request.cyc = 1'b1;
        wb_request.stb = 1'b1;
        wb_request.we  = write;
        wb_request.adr = address;
        wb_request.dat = write_data;
        @(negedge clock);
        while (!wb_response.ack)
        begin
            cycles++;
            if (cycles > 16)
                abort_run("Timeout waiting for Wishbone ack");
            @(negedge clock);
        end
        read_data      = wb_response.dat;
        wb_request.cyc = 1'b0;  // we, adr and dat stay until the next access
        wb_request.stb = 1'b0;
        @(negedge clock);
    endtask

    task automatic read_register(input logic [1:0] address, output logic [31:0] data);
        bus_access(1'b0, address, 32'h0, data);
    endtask

    task automatic write_register(input logic [1:0] address, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, address, data, unused);
    endtask

    task automatic wait_for_count(input int target);
        logic [31:0] status;
        int          polls;
        polls = 0;
        read_register(reg_status_address, status);
        while (status[fifo_count_width-1:0] != fifo_count_width'(target))
        begin
            polls++;
            if (polls > 20)
                abort_run("Timeout waiting for the FIFO count to reach its target");
            repeat (clock_cycles_in_symbol) @(negedge clock);
            read_register(reg_status_address, status);
        end
    endtask

    // ************************************************************************
    // Test sequence

    initial
    begin
        logic [31:0] word;

        void'($urandom(32'h67d));
        clock         = 1'b0;
        reset_n       = 1'b0;
        rx            = 1'b1;
        wb_request    = '0;
        model_overrun = 1'b0;
        test_name     = "reset";
        repeat (4) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);

        test_name = "reset_state";
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);
        read_register(reg_data_address, word);  // Empty read

        test_name = "single_byte";
        send_frame(8'($urandom()), 1'b1);
        wait_for_count(1);
        read_register(reg_data_address, word);
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);

        test_name = "five_bytes";
        repeat (5) send_frame(8'($urandom()), 1'b1);
        wait_for_count(5);
        repeat (5) read_register(reg_data_address, word);
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);

        test_name = "stop_error";
        send_frame(8'($urandom()), 1'b0);
        wait_for_count(1);
        read_register(reg_data_address, word);

        test_name = "overrun";
        repeat (fifo_depth + 2) send_frame(8'($urandom()), 1'b1);
        wait_for_count(fifo_depth);
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);
        repeat (fifo_depth) read_register(reg_data_address, word);
        read_register(reg_data_address, word);  // Drained
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);
        write_register(reg_status_address, 32'h100);
        model_overrun = 1'b0;
        read_register(reg_status_address, word);
        check_value(test_name, expected_status_word(), word);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/uart_rx_pkg.sv
uart_receiver/uart_receiver.sv
source/rx_fifo.sv
source/rx_wb_port.sv
source/uart_rx_top.sv
dv/uart_rx_properties.sv
dv/uart_rx_tb.sv

// File: Makefile
TOP := uart_rx_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
